/* hw/d_cache_param_pkg.sv */
//============================================================
// d-cache geometry and address map
//============================================================

package d_cache_param_pkg;

  //============================================================
  // cache geometry
  //============================================================
  localparam int ADDR_WIDTH      = 20;   // request address
  localparam int NUM_WAYS        = 4;    // 4-way set associative
  localparam int WAY_WIDTH       = 2;    // encoded way
  localparam int NUM_SETS        = 16;
  localparam int SET_WIDTH       = 4;
  localparam int TAG_WIDTH       = 12;
  localparam int OFFSET_WIDTH    = 4;    // byte offset inside a line
  localparam int WORD_WIDTH      = 32;
  localparam int NUM_WORDS_IN_CL = 4;
  localparam int CL_WIDTH        = NUM_WORDS_IN_CL * WORD_WIDTH;  // 128 bit line

  // data array index is {set, way}
  localparam int CL_ADDR_WIDTH   = SET_WIDTH + WAY_WIDTH;

  //============================================================
  // address fields, low to high
  //============================================================
  localparam int LSB_OFFSET      = 0;
  localparam int MSB_OFFSET      = LSB_OFFSET + OFFSET_WIDTH - 1;  // bit 3
  localparam int LSB_SET         = MSB_OFFSET + 1;                 // bit 4
  localparam int MSB_SET         = LSB_SET + SET_WIDTH - 1;        // bit 7
  localparam int LSB_TAG         = MSB_SET + 1;                    // bit 8
  localparam int MSB_TAG         = LSB_TAG + TAG_WIDTH - 1;        // bit 19

  // word select sits in offset bits 2..3
  localparam int LSB_WORD_OFFSET = 2;
  localparam int MSB_WORD_OFFSET = 3;

endpackage

/* hw/d_cache_types_pkg.sv */
//============================================================
// d-cache opcodes and pipe structs
//============================================================

package d_cache_types_pkg;
  import d_cache_param_pkg::*;

  // opcodes
  typedef enum logic [1:0] {RD_LU, WR_LU, FILL_LU} t_lu_op;
  typedef enum logic [1:0] {NO_RSP, HIT, MISS, FILL} t_lu_result;
  typedef enum logic {FILL_REQ_OP, DIRTY_EVICT_OP} t_fm_opcode;

  // index and vector types
  typedef logic [SET_WIDTH-1:0]     t_set_idx;
  typedef logic [WAY_WIDTH-1:0]     t_way_idx;
  typedef logic [NUM_WAYS-1:0]      t_way_vec;   // one bit per way
  typedef logic [CL_ADDR_WIDTH-1:0] t_cl_addr;   // {set, way}
  typedef logic [TAG_WIDTH-1:0]     t_tag;
  typedef logic [OFFSET_WIDTH-1:0]  t_offset;
  typedef logic [WORD_WIDTH-1:0]    t_word;
  typedef logic [ADDR_WIDTH-1:0]    t_address;
  typedef logic [NUM_WORDS_IN_CL-1:0][WORD_WIDTH-1:0] t_cl_data;

  typedef struct packed {
    logic     valid;
    t_lu_op   lu_op;
    t_address address;
    t_word    data;      // write word
    t_cl_data cl_data;   // fill line
  } t_lu_req;

  typedef struct packed {
    logic       valid;
    t_lu_op     lu_op;
    t_lu_result lu_result;
    t_address   address;
    t_cl_data   cl_data;
  } t_lu_rsp;

  typedef struct packed {
    logic                valid;
    t_fm_opcode          opcode;
    t_address            address;
    logic [CL_WIDTH-1:0] data;     // evicted line, zero on fill request
  } t_fm_req;

  // one tag array entry, a whole set
  typedef struct packed {
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;
    t_way_vec                           valid;
    t_way_vec                           modified;
    t_way_vec                           mru;
  } t_set_entry;

  // state handed from q2 to q3
  typedef struct packed {
    logic     valid;
    t_lu_op   lu_op;
    t_tag     tag;
    t_set_idx set;
    t_offset  offset;
    t_word    data;
    t_cl_data cl_data;
    logic     hit;
    logic     miss;
    t_cl_addr cl_addr;      // data array line picked at q2
    logic     dirty_evict;
    t_tag     evict_tag;    // victim tag before the fill
  } t_pipe_bus;

endpackage

/* hw/cache_array.sv */
//============================================================
// synchronous-read cache array
//============================================================

module cache_array #(
  parameter type t_entry = logic,
  parameter int  DEPTH   = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output t_entry                   rd_data,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  t_entry                   wr_data
);

  t_entry mem [DEPTH];

  always_ff @(posedge clk) begin
    // registered read, a same-edge write is seen next cycle
    rd_data <= mem[rd_addr];
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;   // all ways invalid after reset
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

/* hw/tag_stage.sv */
//============================================================
// tag stage, q1 decode and q2 set lookup
//============================================================

module tag_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  d_cache_types_pkg::t_lu_req    lu_req,
  output d_cache_types_pkg::t_set_idx   set_rd_addr,
  input  d_cache_types_pkg::t_set_entry set_rd_data,
  output logic                          set_wr_en,
  output d_cache_types_pkg::t_set_idx   set_wr_addr,
  output d_cache_types_pkg::t_set_entry set_wr_data,
  output d_cache_types_pkg::t_cl_addr   cl_rd_addr,
  output d_cache_types_pkg::t_pipe_bus  stage_q3
);
  import d_cache_param_pkg::*;
  import d_cache_types_pkg::*;

  t_pipe_bus  pipe_q1;          // decoded request
  t_pipe_bus  pipe_q2;          // registered request
  t_pipe_bus  bus_q2;           // q2 results added
  t_set_entry set_q2;           // set after forwarding
  t_set_entry set_upd_q2;       // set to write back
  logic       set_wr_en_q3;     // last cycle's set write
  t_set_idx   set_wr_addr_q3;
  t_set_entry set_wr_data_q3;
  logic       fwd_q2;
  logic       is_fill_q2;
  logic       any_hit_q2;
  logic       any_free_q2;
  t_way_vec   hit_vec_q2;
  t_way_idx   hit_way_q2;
  t_way_idx   victim_way_q2;
  t_way_idx   sel_way_q2;       // way touched by this lookup
  t_way_vec   sel_vec_q2;

  //============================================================
  // q1
  //============================================================
  assign set_rd_addr = lu_req.address[MSB_SET:LSB_SET];   // tag array read

  always_comb begin
    pipe_q1         = '0;
    pipe_q1.valid   = lu_req.valid;
    pipe_q1.lu_op   = lu_req.lu_op;
    pipe_q1.tag     = lu_req.address[MSB_TAG:LSB_TAG];
    pipe_q1.set     = lu_req.address[MSB_SET:LSB_SET];
    pipe_q1.offset  = lu_req.address[MSB_OFFSET:LSB_OFFSET];
    pipe_q1.data    = lu_req.data;
    pipe_q1.cl_data = lu_req.cl_data;
  end

  //============================================================
  // q2
  //============================================================
  // q3 set write lands on the same edge as our read, so take it directly
  assign fwd_q2 = set_wr_en_q3 && pipe_q2.valid && (set_wr_addr_q3 == pipe_q2.set);
  assign set_q2 = fwd_q2 ? set_wr_data_q3 : set_rd_data;

  assign is_fill_q2 = (pipe_q2.lu_op == FILL_LU);

  // tag compare, lowest matching way wins
  always_comb begin
    hit_way_q2 = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec_q2[w] = set_q2.valid[w] && (set_q2.tags[w] == pipe_q2.tag);
      if (hit_vec_q2[w]) hit_way_q2 = t_way_idx'(w);
    end
  end
  assign any_hit_q2 = |hit_vec_q2;

  // victim: first invalid way, else first way with mru clear
  assign any_free_q2 = |(~set_q2.valid);

  always_comb begin
    victim_way_q2 = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (any_free_q2 ? !set_q2.valid[w] : !set_q2.mru[w]) begin
        victim_way_q2 = t_way_idx'(w);
      end
    end
  end

  assign sel_way_q2 = is_fill_q2 ? victim_way_q2 : hit_way_q2;
  assign sel_vec_q2 = t_way_vec'(1) << sel_way_q2;

  always_comb begin
    bus_q2             = pipe_q2;
    bus_q2.hit         = pipe_q2.valid && !is_fill_q2 && any_hit_q2;
    bus_q2.miss        = pipe_q2.valid && !is_fill_q2 && !any_hit_q2;
    bus_q2.cl_addr     = {pipe_q2.set, sel_way_q2};
    bus_q2.dirty_evict = pipe_q2.valid && is_fill_q2 &&
                         set_q2.valid[victim_way_q2] && set_q2.modified[victim_way_q2];
    bus_q2.evict_tag   = set_q2.tags[victim_way_q2];   // old tag of the victim
  end

  // set state update
  always_comb begin
    set_upd_q2 = set_q2;   // misses leave the set as is
    if (bus_q2.hit) begin
      set_upd_q2.mru = set_q2.mru | sel_vec_q2;
      if (pipe_q2.lu_op == WR_LU) begin
        set_upd_q2.modified = set_q2.modified | sel_vec_q2;
      end
    end
    if (is_fill_q2) begin
      set_upd_q2.tags[victim_way_q2] = pipe_q2.tag;
      set_upd_q2.valid               = set_q2.valid | sel_vec_q2;
      set_upd_q2.mru                 = set_q2.mru | sel_vec_q2;
      set_upd_q2.modified            = set_q2.modified & ~sel_vec_q2;   // fills are clean
    end
    // plru flip, keep only the way just used
    if (&set_upd_q2.mru) set_upd_q2.mru = sel_vec_q2;
  end

  assign set_wr_en   = pipe_q2.valid;
  assign set_wr_addr = pipe_q2.set;
  assign set_wr_data = set_upd_q2;
  assign cl_rd_addr  = bus_q2.cl_addr;   // data array read

  //============================================================
  // pipe registers
  //============================================================
  always_ff @(posedge clk) begin
    pipe_q2        <= pipe_q1;
    stage_q3       <= bus_q2;
    set_wr_en_q3   <= set_wr_en;
    set_wr_addr_q3 <= set_wr_addr;
    set_wr_data_q3 <= set_wr_data;
    if (reset) begin
      pipe_q2.valid  <= 1'b0;
      stage_q3.valid <= 1'b0;
      set_wr_en_q3   <= 1'b0;
    end
  end

endmodule

/* hw/data_stage.sv */
//============================================================
// data stage, q3 response and line write
//============================================================

module data_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  d_cache_types_pkg::t_pipe_bus stage_q3,
  input  d_cache_types_pkg::t_cl_data  cl_rd_data,
  output logic                         cl_wr_en,
  output d_cache_types_pkg::t_cl_addr  cl_wr_addr,
  output d_cache_types_pkg::t_cl_data  cl_wr_data,
  output d_cache_types_pkg::t_lu_rsp   lu_rsp,
  output d_cache_types_pkg::t_fm_req   fm_req
);
  import d_cache_param_pkg::*;
  import d_cache_types_pkg::*;

  logic     wr_en_q4;       // previous line write
  t_cl_addr wr_addr_q4;
  t_cl_data wr_data_q4;
  logic     fwd_q3;
  t_cl_data line_q3;        // stored line after forwarding
  t_cl_data merged_q3;      // line with the write word replaced
  logic     is_fill_q3;
  logic     is_rd_q3;
  logic     is_wr_q3;
  logic [MSB_WORD_OFFSET-LSB_WORD_OFFSET:0] word_sel_q3;

  //============================================================
  // line forwarding
  //============================================================
  // array read raced last cycle's write to the same line
  assign fwd_q3  = wr_en_q4 && (wr_addr_q4 == stage_q3.cl_addr);
  assign line_q3 = fwd_q3 ? wr_data_q4 : cl_rd_data;

  assign is_fill_q3 = (stage_q3.lu_op == FILL_LU);
  assign is_rd_q3   = (stage_q3.lu_op == RD_LU);
  assign is_wr_q3   = (stage_q3.lu_op == WR_LU);

  assign word_sel_q3 = stage_q3.offset[MSB_WORD_OFFSET:LSB_WORD_OFFSET];

  always_comb begin
    merged_q3              = line_q3;
    merged_q3[word_sel_q3] = stage_q3.data;   // word merge
  end

  //============================================================
  // response
  //============================================================
  always_comb begin
    lu_rsp         = '0;
    lu_rsp.valid   = stage_q3.valid;
    lu_rsp.lu_op   = stage_q3.lu_op;
    lu_rsp.address = {stage_q3.tag, stage_q3.set, stage_q3.offset};
    if (!stage_q3.valid) lu_rsp.lu_result = NO_RSP;
    else if (is_fill_q3) lu_rsp.lu_result = FILL;
    else if (stage_q3.hit) lu_rsp.lu_result = HIT;
    else lu_rsp.lu_result = MISS;
    if (is_fill_q3) lu_rsp.cl_data = stage_q3.cl_data;       // echo the fill line
    else if (is_rd_q3 && stage_q3.hit) lu_rsp.cl_data = line_q3;
  end

  //============================================================
  // data array write
  //============================================================
  assign cl_wr_en   = stage_q3.valid && (is_fill_q3 || (is_wr_q3 && stage_q3.hit));
  assign cl_wr_addr = stage_q3.cl_addr;
  assign cl_wr_data = is_fill_q3 ? stage_q3.cl_data : merged_q3;

  //============================================================
  // far memory
  //============================================================
  always_comb begin
    fm_req = '0;
    if (stage_q3.valid && is_fill_q3 && stage_q3.dirty_evict) begin
      // modified victim goes back, line aligned
      fm_req.valid   = 1'b1;
      fm_req.opcode  = DIRTY_EVICT_OP;
      fm_req.address = {stage_q3.evict_tag, stage_q3.set, {OFFSET_WIDTH{1'b0}}};
      fm_req.data    = line_q3;
    end else if (stage_q3.valid && !is_fill_q3 && stage_q3.miss) begin
      fm_req.valid   = 1'b1;   // rd or wr miss
      fm_req.opcode  = FILL_REQ_OP;
      fm_req.address = {stage_q3.tag, stage_q3.set, stage_q3.offset};
    end
  end

  // q4 copy of the line write
  always_ff @(posedge clk) begin
    wr_addr_q4 <= cl_wr_addr;
    wr_data_q4 <= cl_wr_data;
    if (reset) wr_en_q4 <= 1'b0;
    else wr_en_q4 <= cl_wr_en;
  end

endmodule

/* hw/d_cache_pipe.sv */
//============================================================
// d-cache lookup pipe top
//============================================================

module d_cache_pipe #(
  parameter int TAG_DEPTH  = d_cache_param_pkg::NUM_SETS,
  parameter int DATA_DEPTH = d_cache_param_pkg::NUM_SETS * d_cache_param_pkg::NUM_WAYS
) (
  input  logic                       clk,
  input  logic                       reset,
  input  d_cache_types_pkg::t_lu_req lu_req,
  output d_cache_types_pkg::t_lu_rsp lu_rsp,
  output d_cache_types_pkg::t_fm_req fm_req
);
  import d_cache_types_pkg::*;

  // tag array
  t_set_idx   set_rd_addr;
  t_set_entry set_rd_data;
  logic       set_wr_en;
  t_set_idx   set_wr_addr;
  t_set_entry set_wr_data;

  // data array
  t_cl_addr   cl_rd_addr;
  t_cl_data   cl_rd_data;
  logic       cl_wr_en;
  t_cl_addr   cl_wr_addr;
  t_cl_data   cl_wr_data;

  t_pipe_bus  stage_q3;   // q2 -> q3

  //============================================================
  // stages
  //============================================================
  tag_stage i_tag_stage (
    .clk         (clk),
    .reset       (reset),
    .lu_req      (lu_req),
    .set_rd_addr (set_rd_addr),
    .set_rd_data (set_rd_data),
    .set_wr_en   (set_wr_en),
    .set_wr_addr (set_wr_addr),
    .set_wr_data (set_wr_data),
    .cl_rd_addr  (cl_rd_addr),
    .stage_q3    (stage_q3)
  );

  data_stage i_data_stage (
    .clk        (clk),
    .reset      (reset),
    .stage_q3   (stage_q3),
    .cl_rd_data (cl_rd_data),
    .cl_wr_en   (cl_wr_en),
    .cl_wr_addr (cl_wr_addr),
    .cl_wr_data (cl_wr_data),
    .lu_rsp     (lu_rsp),
    .fm_req     (fm_req)
  );

  //============================================================
  // arrays
  //============================================================
  cache_array #(.t_entry(t_set_entry), .DEPTH(TAG_DEPTH)) i_tag_array (
    .clk     (clk),
    .reset   (reset),
    .rd_addr (set_rd_addr),
    .rd_data (set_rd_data),
    .wr_en   (set_wr_en),
    .wr_addr (set_wr_addr),
    .wr_data (set_wr_data)
  );

  cache_array #(.t_entry(t_cl_data), .DEPTH(DATA_DEPTH)) i_data_array (
    .clk     (clk),
    .reset   (reset),
    .rd_addr (cl_rd_addr),
    .rd_data (cl_rd_data),
    .wr_en   (cl_wr_en),
    .wr_addr (cl_wr_addr),
    .wr_data (cl_wr_data)
  );

endmodule

/* verification/d_cache_checker.sv */
//============================================================
// d-cache reference model and checker
//============================================================

module d_cache_checker (
  input logic                       clk,
  input logic                       reset,
  input d_cache_types_pkg::t_lu_req lu_req,
  input d_cache_types_pkg::t_lu_rsp lu_rsp,
  input d_cache_types_pkg::t_fm_req fm_req
);
  timeunit 1ns;
  timeprecision 1ps;
  import d_cache_param_pkg::*;
  import d_cache_types_pkg::*;

  // model state per set and way
  t_tag     m_tag  [NUM_SETS][NUM_WAYS];
  t_cl_data m_line [NUM_SETS][NUM_WAYS];
  t_way_vec m_valid [NUM_SETS];
  t_way_vec m_mod   [NUM_SETS];
  t_way_vec m_mru   [NUM_SETS];

  t_lu_rsp exp_rsp_q [$];   // holds the next 2 cycles of expected outputs
  t_fm_req exp_fm_q  [$];
  string   test_name    = "none";
  int      pending      = 0;   // requests whose response has not come back
  int      test_checks  = 0;
  int      test_errors  = 0;
  int      test_evicts  = 0;
  int      total_checks = 0;
  int      total_errors = 0;
  int      num_tests    = 0;

  function automatic void clear_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mod[s]   = '0;
      m_mru[s]   = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]  = '0;
        m_line[s][w] = '0;
      end
    end
  endfunction

  //============================================================
  // model of one request in program order
  //============================================================
  function automatic void predict(input t_lu_req r, output t_lu_rsp rsp, output t_fm_req fm);
    t_set_idx   set;
    t_tag       tag;
    logic [1:0] word;
    int         way;
    set  = r.address[MSB_SET:LSB_SET];
    tag  = r.address[MSB_TAG:LSB_TAG];
    word = r.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET];
    way  = -1;
    rsp  = '0;
    fm   = '0;
    rsp.valid   = 1'b1;
    rsp.lu_op   = r.lu_op;
    rsp.address = r.address;
    if (r.lu_op == FILL_LU) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way < 0 && !m_valid[set][w]) way = w;   // free way
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way < 0 && !m_mru[set][w]) way = w;     // else lru
      end
      if (m_valid[set][way] && m_mod[set][way]) begin
        fm.valid   = 1'b1;
        fm.opcode  = DIRTY_EVICT_OP;
        fm.address = {m_tag[set][way], set, 4'h0};
        fm.data    = m_line[set][way];
      end
      m_tag[set][way]   = tag;
      m_line[set][way]  = r.cl_data;
      m_valid[set][way] = 1'b1;
      m_mod[set][way]   = 1'b0;   // clean fill
      rsp.lu_result     = FILL;
      rsp.cl_data       = r.cl_data;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way < 0 && m_valid[set][w] && m_tag[set][w] == tag) way = w;
      end
      if (way < 0) begin
        rsp.lu_result = MISS;
        fm.valid      = 1'b1;   // fetch from far memory
        fm.opcode     = FILL_REQ_OP;
        fm.address    = r.address;
      end else begin
        rsp.lu_result = HIT;
        if (r.lu_op == RD_LU) begin
          rsp.cl_data = m_line[set][way];
        end else begin
          m_line[set][way][word] = r.data;
          m_mod[set][way]        = 1'b1;
        end
      end
    end
    if (way >= 0) begin
      m_mru[set][way] = 1'b1;
      if (&m_mru[set]) begin
        m_mru[set]      = '0;   // flip so only this way stays
        m_mru[set][way] = 1'b1;
      end
    end
  endfunction

  //============================================================
  // reporting
  //============================================================
  task automatic count_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    count_error();
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
    test_evicts = 0;
  endtask

  // exp_evicts below zero means no count is expected
  task automatic finish_test(input int exp_evicts);
    if (exp_evicts >= 0) begin
      test_checks++;
      total_checks++;
      if (test_evicts != exp_evicts) begin
        $display("FAIL %s dirty evicts expected %0d actual %0d", test_name, exp_evicts,
                 test_evicts);
        count_error();
      end
    end
    num_tests++;
    $display("test %-16s %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic report_totals();
    $display("summary: %0d tests, %0d checks, %0d errors", num_tests, total_checks,
             total_errors);
  endtask

  task automatic compare_outputs(input t_lu_rsp e_rsp, input t_fm_req e_fm);
    test_checks  += 2;
    total_checks += 2;
    if (e_rsp.valid && lu_rsp.valid !== 1'b1) report_failure("expected lu_rsp is missing");
    else if (!e_rsp.valid && lu_rsp.valid !== 1'b0) report_failure("unexpected lu_rsp strobe");
    else if (e_rsp.valid && lu_rsp !== e_rsp) begin
      $display("FAIL %s lu_rsp expected %h actual %h", test_name, e_rsp, lu_rsp);
      count_error();
    end
    if (e_fm.valid && fm_req.valid !== 1'b1) report_failure("expected fm_req is missing");
    else if (!e_fm.valid && fm_req.valid !== 1'b0) report_failure("unexpected fm_req strobe");
    else if (e_fm.valid && fm_req !== e_fm) begin
      $display("FAIL %s fm_req expected %h actual %h", test_name, e_fm, fm_req);
      count_error();
    end
  endtask

  // sample mid cycle when request and response have settled
  always @(negedge clk) begin
    t_lu_rsp e_rsp;
    t_fm_req e_fm;
    if (reset) begin
      clear_model();
      exp_rsp_q.delete();
      exp_fm_q.delete();
      pending = 0;
      repeat (2) begin
        exp_rsp_q.push_back('0);
        exp_fm_q.push_back('0);
      end
      test_checks++;
      total_checks++;
      if (lu_rsp.valid !== 1'b0 || fm_req.valid !== 1'b0) begin
        report_failure("output strobe active during reset");
      end
    end else begin
      e_rsp = '0;
      e_fm  = '0;
      if (lu_req.valid) begin
        predict(lu_req, e_rsp, e_fm);
        pending++;
      end
      exp_rsp_q.push_back(e_rsp);
      exp_fm_q.push_back(e_fm);
      e_rsp = exp_rsp_q.pop_front();   // request from two cycles ago
      e_fm  = exp_fm_q.pop_front();
      if (lu_rsp.valid === 1'b1) pending--;   // response seen from the DUT
      compare_outputs(e_rsp, e_fm);
      if (fm_req.valid === 1'b1 && fm_req.opcode == DIRTY_EVICT_OP) test_evicts++;
    end
  end

endmodule

/* verification/d_cache_tb.sv */
//============================================================
// d-cache pipe testbench
//============================================================

module d_cache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import d_cache_param_pkg::*;
  import d_cache_types_pkg::*;

  localparam int DRAIN_LIMIT = 20;   // cycles to wait for outstanding responses

  logic    clk;
  logic    reset;
  t_lu_req lu_req;
  t_lu_rsp lu_rsp;
  t_fm_req fm_req;

  d_cache_pipe #(
    .TAG_DEPTH  (NUM_SETS),
    .DATA_DEPTH (NUM_SETS * NUM_WAYS)
  ) i_d_cache_pipe (
    .clk    (clk),
    .reset  (reset),
    .lu_req (lu_req),
    .lu_rsp (lu_rsp),
    .fm_req (fm_req)
  );

  d_cache_checker i_checker (
    .clk    (clk),
    .reset  (reset),
    .lu_req (lu_req),
    .lu_rsp (lu_rsp),
    .fm_req (fm_req)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  function automatic t_cl_data random_line();
    t_cl_data line;
    for (int w = 0; w < NUM_WORDS_IN_CL; w++) line[w] = $urandom;
    return line;
  endfunction

  task automatic issue(input t_lu_op op, input t_address addr, input t_word data,
                       input t_cl_data line);
    t_lu_req r;
    r.valid   = 1'b1;
    r.lu_op   = op;
    r.address = addr;
    r.data    = data;
    r.cl_data = line;
    @(posedge clk);
    lu_req <= r;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      lu_req.valid <= 1'b0;
    end
  endtask

  // wait until the checker has seen every response due
  task automatic drain();
    int waited;
    waited = 0;
    idle(1);
    while (i_checker.pending != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (i_checker.pending != 0) i_checker.report_failure("responses still due after timeout");
  endtask

  initial begin
    t_tag     tags [3];
    t_set_idx sets [2];
    t_address addr;
    int       pick;
    void'($urandom(86));
    tags   = '{12'h0a1, 12'h0b2, 12'h0c3};
    sets   = '{4'h2, 4'h3};
    reset  = 1'b1;
    lu_req = '0;

    //==========================================================
    // directed tests
    //==========================================================
    i_checker.start_test("reset_idle");
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    idle(10);
    i_checker.finish_test(-1);

    i_checker.start_test("read_miss");
    issue(RD_LU, {12'h123, 4'h5, 4'h8}, '0, '0);
    drain();
    i_checker.finish_test(0);

    i_checker.start_test("fill_then_hit");
    issue(FILL_LU, {12'h123, 4'h5, 4'h0}, '0, random_line());
    issue(RD_LU, {12'h123, 4'h5, 4'hc}, '0, '0);   // same set, back to back
    drain();
    i_checker.finish_test(0);

    i_checker.start_test("write_merge");
    issue(WR_LU, {12'h123, 4'h5, 4'h4}, $urandom, '0);
    issue(RD_LU, {12'h123, 4'h5, 4'h0}, '0, '0);   // same line, data forwarded
    drain();
    i_checker.finish_test(0);

    i_checker.start_test("dirty_evict");
    for (int i = 0; i < 4; i++) issue(FILL_LU, {t_tag'(i) + 12'h200, 4'h9, 4'h0}, '0,
                                      random_line());
    issue(WR_LU, {12'h201, 4'h9, 4'h8}, $urandom, '0);   // way 1 becomes modified
    for (int i = 4; i < 8; i++) issue(FILL_LU, {t_tag'(i) + 12'h200, 4'h9, 4'h0}, '0,
                                      random_line());
    drain();
    i_checker.finish_test(1);   // only the fourth refill hits the modified way

    //==========================================================
    // random traffic
    //==========================================================
    i_checker.start_test("random_traffic");
    for (int n = 0; n < 2000; n++) begin
      addr = {tags[$urandom % 3], sets[$urandom % 2], t_offset'($urandom)};
      pick = $urandom % 8;
      if ($urandom % 8 == 0) idle(1);   // occasional bubble
      if (pick < 3) issue(FILL_LU, addr, '0, random_line());
      else if (pick < 5) issue(WR_LU, addr, $urandom, '0);
      else issue(RD_LU, addr, '0, '0);
    end
    drain();
    i_checker.finish_test(-1);

    i_checker.report_totals();
    if (i_checker.total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* d_cache.f */
hw/d_cache_param_pkg.sv
hw/d_cache_types_pkg.sv
hw/cache_array.sv
hw/tag_stage.sv
hw/data_stage.sv
hw/d_cache_pipe.sv
verification/d_cache_checker.sv
verification/d_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the d-cache testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f d_cache.f --top-module d_cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vd_cache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# verdict comes from the log only
if grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
